/* build.f */
+incdir+hw
hw/priv_pkg.sv
hw/priv_exec.sv
hw/csr_file.sv
hw/tlb_ctrl.sv
hw/cacop_engine.sv
hw/priv_top.sv
test/tb_priv_top.sv

/* hw/cacop_engine.sv */
`default_nettype none
`timescale 1ns/1ns
`include "priv_config.svh"

module cacop_engine #(
    parameter type rpt_t = priv_pkg::cacop_rpt_t
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 en,
    input  priv_pkg::cacop_req_t req,
    output logic                 ready,
    output logic                 complete,
    output rpt_t                 rpt
);
    import priv_pkg::*;

    localparam int  CW    = $clog2(`PRIV_CACOP_LATENCY + 1);
    localparam bit  IS_L1 = ($bits(rpt_t) == $bits(cacop_rpt_t));
    localparam int  RW    = $bits(cacop_rpt_t);

    logic [CW-1:0] cnt;
    logic          err_q;      // misaligned hit op
    logic [31:0]   addr_q;
    logic [RW-1:0] rpt_bits;

    assign ready = (cnt == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt      <= '0;
            complete <= 1'b0;
        end else begin
            complete <= (cnt == CW'(1));
            if (en && ready)    cnt <= CW'(`PRIV_CACOP_LATENCY);
            else if (cnt != '0) cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (en && ready) begin
            err_q  <= (req.code == 2'd2) && (req.vaddr[1:0] != 2'b00);
            addr_q <= req.vaddr;
        end
    end

    // l1 reports {exp, badv} on complete, l2 only a done bit
    assign rpt_bits = IS_L1 ? {(complete && err_q) ? `EXC_ALE : 7'h0,
                               (complete && err_q) ? addr_q : 32'h0}
                            : {{(RW-1){1'b0}}, complete};
    assign rpt = rpt_bits[$bits(rpt_t)-1:0];

    // sequencer only requests an idle engine
    a_en_when_ready: assert property (@(posedge clk) disable iff (!rstn) en |-> ready);

endmodule

`default_nettype wire

/* hw/csr_file.sv */
`default_nettype none
`timescale 1ns/1ns
`include "priv_config.svh"

module csr_file (
    input  logic                    clk,
    input  logic                    rstn,
    input  priv_pkg::csr_req_t      csr,
    input  logic                    restore_state,
    input  priv_pkg::tlb_csr_upd_t  upd,
    input  logic                    index_we,
    input  logic                    e_we,
    input  logic                    other_we,
    output logic [31:0]             rdata,
    output logic [31:0]             era,
    output priv_pkg::csr_tlb_view_t view
);
    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] tlbidx;   // ne at bit 31
    logic [31:0] tlbehi;
    logic [31:0] tlbelo0;
    logic [31:0] asid;

    function automatic logic sw_hit(input logic [13:0] a);
        return csr.query_en && (csr.addr == a);
    endfunction

    function automatic logic [31:0] masked(input logic [31:0] old);
        return (old & ~csr.wen) | (csr.wdata & csr.wen);
    endfunction

    always_comb begin
        case (csr.addr)
            `CSR_CRMD:    rdata = crmd;
            `CSR_PRMD:    rdata = prmd;
            `CSR_ERA:     rdata = era;
            `CSR_TLBIDX:  rdata = tlbidx;
            `CSR_TLBEHI:  rdata = tlbehi;
            `CSR_TLBELO0: rdata = tlbelo0;
            `CSR_ASID:    rdata = asid;
            default:      rdata = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd    <= 32'h0000_0008; // da set out of reset
            prmd    <= '0;
            era     <= '0;
            tlbidx  <= '0;
            tlbehi  <= '0;
            tlbelo0 <= '0;
            asid    <= '0;
        end else begin
            if (sw_hit(`CSR_CRMD))   crmd <= masked(crmd);
            else if (restore_state)  crmd[2:0] <= prmd[2:0]; // pie, pplv
            if (sw_hit(`CSR_PRMD))   prmd <= masked(prmd);
            if (sw_hit(`CSR_ERA))    era  <= masked(era);
            if (sw_hit(`CSR_TLBIDX)) begin
                tlbidx <= masked(tlbidx);
            end else if (index_we) begin
                tlbidx[2:0] <= upd.index;
                tlbidx[31]  <= upd.ne;
            end
            if (sw_hit(`CSR_TLBEHI))  tlbehi <= masked(tlbehi);
            else if (e_we)            tlbehi <= {upd.vppn, 13'h0};
            if (sw_hit(`CSR_TLBELO0)) tlbelo0 <= masked(tlbelo0);
            else if (e_we)            tlbelo0 <= {4'h0, upd.ppn, 7'h0, upd.valid};
            if (sw_hit(`CSR_ASID))    asid <= masked(asid);
            else if (other_we)        asid[9:0] <= upd.asid;
        end
    end

    assign view.index = tlbidx[2:0];
    assign view.vppn  = tlbehi[31:13];
    assign view.ppn   = tlbelo0[27:8];
    assign view.valid = tlbelo0[0];
    assign view.asid  = asid[9:0];

    // ertn and a csr write come from different instructions
    a_no_wr_on_restore: assert property (@(posedge clk) disable iff (!rstn)
        !(csr.query_en && (|csr.wen) && restore_state));

endmodule

`default_nettype wire

/* hw/priv_config.svh */
`ifndef PRIV_CONFIG_SVH
`define PRIV_CONFIG_SVH

// sizes and timing
`define PRIV_TLB_ENTRIES   8
`define PRIV_CACOP_LATENCY 3

// csr addresses
`define CSR_CRMD    14'h0
`define CSR_PRMD    14'h1
`define CSR_ERA     14'h6
`define CSR_TLBIDX  14'h10
`define CSR_TLBEHI  14'h11
`define CSR_TLBELO0 14'h12
`define CSR_ASID    14'h18

`define EXC_ALE 7'h09 // address not aligned

`endif

/* hw/priv_exec.sv */
`default_nettype none
`timescale 1ns/1ns

module priv_exec (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 en_in,
    input  priv_pkg::priv_req_t  req,
    output logic                 stall,
    output logic                 en_out,
    output logic                 flush,
    output priv_pkg::priv_rsp_t  rsp,
    output priv_pkg::csr_req_t   csr,
    input  logic [31:0]          csr_rdata,   // old value, read before write
    input  logic [31:0]          era,
    output logic                 restore_state,
    output priv_pkg::tlb_cmd_t   tlb,
    output priv_pkg::cacop_req_t cop,
    output logic                 l1i_en,
    output logic                 l1d_en,
    output logic                 l2_en,
    input  logic                 l1i_ready,
    input  logic                 l1d_ready,
    input  logic                 l2_ready,
    input  logic                 l1i_complete,
    input  logic                 l1d_complete,
    input  logic                 l2_complete,
    input  priv_pkg::cacop_rpt_t l1i_rpt,
    input  priv_pkg::cacop_rpt_t l1d_rpt
);
    import priv_pkg::*;

    typedef enum logic [15:0] {
        S_INIT      = 16'h0001,
        S_CSR       = 16'h0002,
        S_ERTN      = 16'h0004,
        S_TLB       = 16'h0008,
        S_TLB_SRCH  = 16'h0010,
        S_TLB_RD    = 16'h0020,
        S_TLB_WR    = 16'h0040,
        S_TLB_FILL  = 16'h0080,
        S_INVTLB    = 16'h0100,
        S_CACOP     = 16'h0200,
        S_C_REQ     = 16'h0400,
        S_C_WAIT    = 16'h0800,
        S_DONE_CSR  = 16'h1000,
        S_DONE_ERTN = 16'h2000,
        S_DONE_TLB  = 16'h4000,
        S_DONE_C    = 16'h8000
    } state_t;

    state_t      state;
    state_t      next_state;
    logic [31:0] inst_q;        // held for tlb and cacop decode
    logic        sel_ready;
    logic        sel_complete;
    cacop_rpt_t  sel_rpt;

    // inst[1:0] picks the cache, 2 and 3 both go to l2
    always_comb begin
        sel_ready    = l2_ready;
        sel_complete = l2_complete;
        sel_rpt      = '0;
        if (inst_q[1:0] == 2'd0) begin
            sel_ready    = l1i_ready;
            sel_complete = l1i_complete;
            sel_rpt      = l1i_rpt;
        end else if (inst_q[1:0] == 2'd1) begin
            sel_ready    = l1d_ready;
            sel_complete = l1d_complete;
            sel_rpt      = l1d_rpt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) state <= S_INIT;
        else       state <= next_state;
    end

    always_comb begin
        next_state = S_INIT;
        case (state)
            S_INIT: begin
                if (en_in && req.op.is_csr)        next_state = S_CSR;
                else if (en_in && req.op.is_ertn)  next_state = S_ERTN;
                else if (en_in && req.op.is_tlb)   next_state = S_TLB;
                else if (en_in && req.op.is_cache) next_state = S_CACOP;
            end
            S_CSR:  next_state = S_DONE_CSR;
            S_ERTN: next_state = S_DONE_ERTN;
            S_TLB: begin
                if (inst_q[16]) begin
                    next_state = S_INVTLB;
                end else begin
                    case (inst_q[11:10])
                        2'b10:   next_state = S_TLB_SRCH;
                        2'b11:   next_state = S_TLB_RD;
                        2'b00:   next_state = S_TLB_WR;
                        default: next_state = S_TLB_FILL;
                    endcase
                end
            end
            S_TLB_SRCH, S_TLB_RD, S_TLB_WR, S_TLB_FILL, S_INVTLB:
                next_state = S_DONE_TLB;
            S_CACOP:  next_state = S_C_REQ;
            S_C_REQ:  next_state = sel_ready ? S_C_WAIT : S_C_REQ;
            S_C_WAIT: next_state = sel_complete ? S_DONE_C : S_C_WAIT;
            default:  next_state = S_INIT;
        endcase
    end

    // outputs registered on the state being entered
    always_ff @(posedge clk) begin
        if (!rstn) begin
            stall         <= 1'b0;
            en_out        <= 1'b0;
            flush         <= 1'b0;
            rsp           <= '0;
            csr           <= '0;
            restore_state <= 1'b0;
            tlb           <= '0;
            cop           <= '0;
            l1i_en        <= 1'b0;
            l1d_en        <= 1'b0;
            l2_en         <= 1'b0;
            inst_q        <= '0;
        end else begin
            case (next_state)
                S_INIT: begin
                    en_out     <= 1'b0;
                    flush      <= 1'b0;
                    rsp.result <= '0;
                    rsp.addr   <= '0;
                    rsp.exp    <= '0;
                    rsp.badv   <= '0;
                end
                S_CSR: begin
                    stall         <= 1'b1;
                    rsp.pc_target <= req.pc_next;
                    rsp.addr      <= req.addr;
                    csr.query_en  <= 1'b1;
                    csr.addr      <= req.imm[13:0];
                    csr.wen       <= (req.inst[9:5] == 5'd1) ? 32'hffff_ffff : req.sr0;
                    csr.wdata     <= req.sr1;
                end
                S_DONE_CSR: begin
                    en_out       <= 1'b1;
                    flush        <= 1'b1;
                    stall        <= 1'b0;
                    rsp.result   <= csr_rdata;
                    csr.query_en <= 1'b0;
                end
                S_ERTN: begin
                    stall         <= 1'b1;
                    rsp.pc_target <= era;
                    restore_state <= 1'b1;
                end
                S_DONE_ERTN: begin
                    restore_state <= 1'b0;
                    en_out        <= 1'b1;
                    flush         <= 1'b1;
                    stall         <= 1'b0;
                end
                S_TLB: begin
                    stall           <= 1'b1;
                    rsp.pc_target   <= req.pc_next;
                    inst_q          <= req.inst;
                    tlb.clear_asid  <= req.sr0[9:0];
                    tlb.clear_vaddr <= req.sr1;
                end
                S_TLB_SRCH: begin
                    tlb.check_mode <= 1'b1;
                    tlb.index_we   <= 1'b1;
                end
                S_TLB_RD: begin
                    tlb.check_mode <= 1'b0;
                    tlb.e_we       <= 1'b1;
                    tlb.other_we   <= 1'b1;
                end
                S_TLB_WR: begin
                    tlb.fill_mode <= 1'b0;
                    tlb.we        <= 1'b1;
                end
                S_TLB_FILL: begin
                    tlb.fill_mode <= 1'b1;
                    tlb.we        <= 1'b1;
                end
                S_INVTLB: tlb.clear_mem <= (inst_q[4:0] == 5'd0) ? 3'd1 : inst_q[2:0];
                S_DONE_TLB: begin
                    tlb.we        <= 1'b0;
                    tlb.index_we  <= 1'b0;
                    tlb.e_we      <= 1'b0;
                    tlb.other_we  <= 1'b0;
                    tlb.clear_mem <= 3'd0;
                    en_out        <= 1'b1;
                    flush         <= 1'b1;
                    stall         <= 1'b0;
                end
                S_CACOP: begin
                    stall         <= 1'b1;
                    rsp.pc_target <= req.pc_next;
                    inst_q        <= req.inst;
                    cop.code      <= req.inst[4:3];
                    cop.vaddr     <= req.sr0 + req.imm;
                end
                S_C_REQ: begin // held until the engine is ready
                    l1i_en <= (inst_q[1:0] == 2'd0);
                    l1d_en <= (inst_q[1:0] == 2'd1);
                    l2_en  <= inst_q[1];
                end
                S_C_WAIT: begin
                    l1i_en <= 1'b0;
                    l1d_en <= 1'b0;
                    l2_en  <= 1'b0;
                end
                S_DONE_C: begin
                    en_out   <= 1'b1;
                    flush    <= 1'b1;
                    stall    <= 1'b0;
                    rsp.exp  <= rsp.exp | sel_rpt.exp;
                    rsp.badv <= rsp.badv | sel_rpt.badv;
                end
                default: ;
            endcase
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot(state));

endmodule

`default_nettype wire

/* hw/priv_pkg.sv */
`default_nettype none

package priv_pkg;

    typedef struct packed {
        logic is_csr;
        logic is_tlb;
        logic is_cache;
        logic is_ertn;
    } priv_op_t;

    typedef struct packed {
        priv_op_t    op;
        logic [31:0] inst;
        logic [31:0] sr0;     // rj
        logic [31:0] sr1;     // rk
        logic [4:0]  addr;    // rd
        logic [31:0] imm;
        logic [31:0] pc_next;
    } priv_req_t;

    typedef struct packed {
        logic [31:0] pc_target;
        logic [31:0] result;
        logic [4:0]  addr;
        logic [6:0]  exp;
        logic [31:0] badv;
    } priv_rsp_t;

    typedef struct packed {
        logic        query_en;
        logic [13:0] addr;
        logic [31:0] wen;     // per-bit write enable
        logic [31:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic        fill_mode;
        logic        check_mode;
        logic        we;
        logic        index_we;
        logic        e_we;
        logic        other_we;
        logic [31:0] clear_vaddr;
        logic [9:0]  clear_asid;
        logic [2:0]  clear_mem;   // invtlb op, 0 means none
    } tlb_cmd_t;

    typedef struct packed {
        logic [2:0]  index;
        logic [18:0] vppn;
        logic [19:0] ppn;
        logic        valid;
        logic [9:0]  asid;
    } csr_tlb_view_t;

    typedef struct packed {
        logic [2:0]  index;
        logic        ne;
        logic [18:0] vppn;
        logic [19:0] ppn;
        logic        valid;
        logic [9:0]  asid;
    } tlb_csr_upd_t;

    typedef struct packed {
        logic [1:0]  code;
        logic [31:0] vaddr;
    } cacop_req_t;

    typedef struct packed {
        logic [6:0]  exp;
        logic [31:0] badv;
    } cacop_rpt_t;

    typedef struct packed {
        logic done;
    } cacop_plain_t;

endpackage

`default_nettype wire

/* hw/priv_top.sv */
`default_nettype none
`timescale 1ns/1ns

module priv_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                en_in,
    input  priv_pkg::priv_req_t req,
    output logic                stall,
    output logic                en_out,
    output logic                flush,
    output priv_pkg::priv_rsp_t rsp
);
    import priv_pkg::*;

    csr_req_t      csr;
    logic [31:0]   csr_rdata;
    logic [31:0]   era;
    logic          restore_state;
    tlb_cmd_t      tlb;
    csr_tlb_view_t view;
    tlb_csr_upd_t  upd;
    logic          index_we;
    logic          e_we;
    logic          other_we;
    cacop_req_t    cop;
    logic          l1i_en;
    logic          l1d_en;
    logic          l2_en;
    logic          l1i_ready;
    logic          l1d_ready;
    logic          l2_ready;
    logic          l1i_complete;
    logic          l1d_complete;
    cacop_rpt_t    l1i_rpt;
    cacop_rpt_t    l1d_rpt;
    cacop_plain_t  l2_rpt;

    priv_exec u_priv_exec (
        .clk           (clk),
        .rstn          (rstn),
        .en_in         (en_in),
        .req           (req),
        .stall         (stall),
        .en_out        (en_out),
        .flush         (flush),
        .rsp           (rsp),
        .csr           (csr),
        .csr_rdata     (csr_rdata),
        .era           (era),
        .restore_state (restore_state),
        .tlb           (tlb),
        .cop           (cop),
        .l1i_en        (l1i_en),
        .l1d_en        (l1d_en),
        .l2_en         (l2_en),
        .l1i_ready     (l1i_ready),
        .l1d_ready     (l1d_ready),
        .l2_ready      (l2_ready),
        .l1i_complete  (l1i_complete),
        .l1d_complete  (l1d_complete),
        .l2_complete   (l2_rpt.done),   // l2 report is its completion
        .l1i_rpt       (l1i_rpt),
        .l1d_rpt       (l1d_rpt)
    );

    csr_file u_csr_file (
        .clk           (clk),
        .rstn          (rstn),
        .csr           (csr),
        .restore_state (restore_state),
        .upd           (upd),
        .index_we      (index_we),
        .e_we          (e_we),
        .other_we      (other_we),
        .rdata         (csr_rdata),
        .era           (era),
        .view          (view)
    );

    tlb_ctrl u_tlb_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .cmd      (tlb),
        .view     (view),
        .upd      (upd),
        .index_we (index_we),
        .e_we     (e_we),
        .other_we (other_we)
    );

    cacop_engine #(.rpt_t(cacop_rpt_t)) u_l1i (
        .clk      (clk),
        .rstn     (rstn),
        .en       (l1i_en),
        .req      (cop),
        .ready    (l1i_ready),
        .complete (l1i_complete),
        .rpt      (l1i_rpt)
    );

    cacop_engine #(.rpt_t(cacop_rpt_t)) u_l1d (
        .clk      (clk),
        .rstn     (rstn),
        .en       (l1d_en),
        .req      (cop),
        .ready    (l1d_ready),
        .complete (l1d_complete),
        .rpt      (l1d_rpt)
    );

    cacop_engine #(.rpt_t(cacop_plain_t)) u_l2 (
        .clk      (clk),
        .rstn     (rstn),
        .en       (l2_en),
        .req      (cop),
        .ready    (l2_ready),
        .complete (),
        .rpt      (l2_rpt)
    );

endmodule

`default_nettype wire

/* hw/tlb_ctrl.sv */
`default_nettype none
`timescale 1ns/1ns
`include "priv_config.svh"

module tlb_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  priv_pkg::tlb_cmd_t      cmd,
    input  priv_pkg::csr_tlb_view_t view,
    output priv_pkg::tlb_csr_upd_t  upd,
    output logic                    index_we,
    output logic                    e_we,
    output logic                    other_we
);
    logic [18:0] e_vppn [`PRIV_TLB_ENTRIES];
    logic [9:0]  e_asid [`PRIV_TLB_ENTRIES];
    logic [19:0] e_ppn  [`PRIV_TLB_ENTRIES];
    logic [`PRIV_TLB_ENTRIES-1:0] e_valid;
    logic [`PRIV_TLB_ENTRIES-1:0] inv;
    logic [2:0] fill_ptr;
    logic [2:0] hit_idx;
    logic       hit;
    logic [2:0] wr_idx;
    logic [2:0] sel_idx;

    // downward scan so the lowest match wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = 3'd0;
        for (int i = `PRIV_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (e_valid[i] && e_vppn[i] == view.vppn && e_asid[i] == view.asid) begin
                hit     = 1'b1;
                hit_idx = 3'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `PRIV_TLB_ENTRIES; i++) begin
            case (cmd.clear_mem)
                3'd1:    inv[i] = 1'b1;
                3'd4:    inv[i] = (e_asid[i] == cmd.clear_asid);
                3'd5:    inv[i] = (e_asid[i] == cmd.clear_asid) &&
                                  (e_vppn[i] == cmd.clear_vaddr[31:13]);
                default: inv[i] = 1'b0;
            endcase
        end
    end

    assign wr_idx  = cmd.fill_mode ? fill_ptr : view.index;
    assign sel_idx = cmd.check_mode ? hit_idx : view.index;

    always_ff @(posedge clk) begin
        if (cmd.we) begin
            e_vppn[wr_idx] <= view.vppn;
            e_asid[wr_idx] <= view.asid;
            e_ppn[wr_idx]  <= view.ppn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            e_valid  <= '0;
            fill_ptr <= 3'd0;
            index_we <= 1'b0;
            e_we     <= 1'b0;
            other_we <= 1'b0;
        end else begin
            e_valid <= e_valid & ~inv;
            if (cmd.we) begin
                e_valid[wr_idx] <= view.valid;
                if (cmd.fill_mode) begin
                    fill_ptr <= (fill_ptr == 3'(`PRIV_TLB_ENTRIES - 1)) ? 3'd0 : fill_ptr + 3'd1;
                end
            end
            index_we <= cmd.index_we; // csr picks these up next cycle
            e_we     <= cmd.e_we;
            other_we <= cmd.other_we;
        end
    end

    always_ff @(posedge clk) begin
        upd <= '{index: sel_idx,
                 ne:    cmd.check_mode && !hit,
                 vppn:  e_vppn[sel_idx],
                 ppn:   e_ppn[sel_idx],
                 valid: e_valid[sel_idx],
                 asid:  e_asid[sel_idx]};
    end

endmodule

`default_nettype wire

/* test/tb_priv_top.sv */
`default_nettype none
`timescale 1ns/1ns
`include "priv_config.svh"

module tb_priv_top;
    import priv_pkg::*;

    localparam int IDLE_LIMIT   = 50;
    localparam int RETIRE_LIMIT = 50;

    // real loongarch encodings, only the decoded fields matter
    localparam logic [31:0] INST_CSR     = 32'h0400_0000;
    localparam logic [31:0] INST_CACOP   = 32'h0600_0000;
    localparam logic [31:0] INST_TLBSRCH = 32'h0648_2800;
    localparam logic [31:0] INST_TLBRD   = 32'h0648_2c00;
    localparam logic [31:0] INST_TLBWR   = 32'h0648_3000;
    localparam logic [31:0] INST_TLBFILL = 32'h0648_3400;
    localparam logic [31:0] INST_ERTN    = 32'h0648_3800;
    localparam logic [31:0] INST_INVTLB  = 32'h0649_8000;

    localparam priv_op_t OP_CSR   = 4'b1000;
    localparam priv_op_t OP_TLB   = 4'b0100;
    localparam priv_op_t OP_CACHE = 4'b0010;
    localparam priv_op_t OP_ERTN  = 4'b0001;

    logic      clk;
    logic      rstn;
    logic      en_in;
    priv_req_t req;
    logic      stall;
    logic      en_out;
    logic      flush;
    priv_rsp_t rsp;

    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          test_err0 = 0;
    string       cur_test = "reset";
    logic [31:0] pc;

    priv_top u_priv_top (
        .clk    (clk),
        .rstn   (rstn),
        .en_in  (en_in),
        .req    (req),
        .stall  (stall),
        .en_out (en_out),
        .flush  (flush),
        .rsp    (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("Mismatch %s %s: expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
    endtask

    task automatic note_failure(input string why);
        errors++;
        $display("Error in %s: %s", cur_test, why);
    endtask

    task automatic abort_run(input string why);
        $display("Error in %s: %s", cur_test, why);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = errors;
        tests++;
    endtask

    task automatic finish_test();
        if (errors != test_err0) failed_tests++;
        $display("%s: %s", cur_test, (errors == test_err0) ? "ok" : "had errors");
    endtask

    function automatic priv_req_t make_req(input priv_op_t op, input logic [31:0] inst,
                                           input logic [31:0] sr0, input logic [31:0] sr1,
                                           input logic [31:0] imm);
        priv_req_t r;
        r.op      = op;
        r.inst    = inst;
        r.sr0     = sr0;
        r.sr1     = sr1;
        r.addr    = inst[4:0];
        r.imm     = imm;
        r.pc_next = pc;
        return r;
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        while (stall) begin
            if (n >= IDLE_LIMIT) abort_run("stall stayed high before an issue");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    // issue one instruction and wait for its retire pulse
    task automatic execute(input priv_req_t r, input int want_lat, output priv_rsp_t got);
        int lat;
        wait_idle();
        @(posedge clk);
        #1;
        en_in = 1'b1;
        req   = r;
        @(posedge clk);
        #1;
        en_in = 1'b0;
        pc    = pc + 32'd4;
        if (!stall) note_failure("stall was low the cycle after an issue");
        lat   = 1;
        while (!en_out) begin
            if (lat >= RETIRE_LIMIT) abort_run("en_out never rose after an issue");
            @(posedge clk);
            #1;
            lat++;
        end
        got = rsp;
        if (!flush) note_failure("flush was low while en_out was high");
        if (stall) note_failure("stall was still high while en_out was high");
        if (want_lat > 0 && lat != want_lat) mismatch("retire latency", want_lat, lat);
        if (!r.op.is_ertn && got.pc_target !== r.pc_next) begin
            mismatch("pc_target", r.pc_next, got.pc_target);
        end
    endtask

    task automatic csr_op(input logic [4:0] rj, input logic [13:0] num, input logic [31:0] mask,
                          input logic [31:0] data, output logic [31:0] old);
        priv_req_t r;
        priv_rsp_t got;
        r = make_req(OP_CSR, INST_CSR | {num, 10'h0} | {rj, 5'h0} | 32'd4, mask, data,
                     {18'h0, num});
        execute(r, 2, got); // csr retires two cycles after issue
        if (got.addr !== 5'd4) mismatch("rd", 32'd4, got.addr);
        old = got.result;
    endtask

    task automatic csr_wr(input logic [13:0] num, input logic [31:0] data, output logic [31:0] old);
        csr_op(5'd1, num, 32'h0, data, old);
    endtask

    task automatic csr_rd(input logic [13:0] num, output logic [31:0] val);
        csr_op(5'd0, num, 32'h0, 32'h0, val);
    endtask

    task automatic tlb_op(input logic [31:0] inst, input logic [31:0] sr0, input logic [31:0] sr1);
        priv_rsp_t got;
        execute(make_req(OP_TLB, inst, sr0, sr1, 32'h0), 3, got);
    endtask

    task automatic cacop(input logic [1:0] code, input logic [1:0] cache, input logic [31:0] base,
                         input logic [11:0] off);
        priv_req_t   r;
        priv_rsp_t   got;
        logic [31:0] va;
        logic [6:0]  want_exp;
        logic [31:0] want_badv;
        va        = base + {{20{off[11]}}, off};
        want_exp  = 7'h0;
        want_badv = 32'h0;
        if (!cache[1] && code == 2'd2 && va[1:0] != 2'b00) begin // l1 hit op, unaligned
            want_exp  = `EXC_ALE;
            want_badv = va;
        end
        r = make_req(OP_CACHE, INST_CACOP | {off, 10'h0} | {5'd6, 5'h0} | {code, 1'b0, cache},
                     base, 32'h0, {{20{off[11]}}, off});
        execute(r, 0, got);
        if (got.exp !== want_exp) mismatch("exp", want_exp, got.exp);
        if (got.badv !== want_badv) mismatch("badv", want_badv, got.badv);
    endtask

    task automatic csr_rw_seq();
        logic [31:0] val;
        start_test("csr_rw");
        csr_wr(`CSR_ERA, 32'h1234, val);
        if (val !== 32'h0) mismatch("csrwr old", 32'h0, val);
        csr_op(5'd2, `CSR_ERA, 32'hff00, 32'habcd, val); // csrxchg
        if (val !== 32'h1234) mismatch("csrxchg old", 32'h1234, val);
        csr_rd(`CSR_ERA, val);
        if (val !== 32'hab34) mismatch("csrrd", 32'hab34, val);
        finish_test();
    endtask

    task automatic ertn_return();
        logic [31:0] val;
        priv_rsp_t   got;
        start_test("ertn");
        csr_wr(`CSR_ERA, 32'h8000_0040, val);
        csr_wr(`CSR_PRMD, 32'h7, val);
        execute(make_req(OP_ERTN, INST_ERTN, 32'h0, 32'h0, 32'h0), 2, got);
        if (got.pc_target !== 32'h8000_0040) mismatch("pc_target", 32'h8000_0040, got.pc_target);
        csr_rd(`CSR_CRMD, val);
        if (val[2:0] !== 3'h7) mismatch("crmd plv/ie", 32'h7, val[2:0]);
        finish_test();
    endtask

    task automatic tlb_fill_search();
        logic [31:0] val;
        start_test("tlb_fill_search");
        csr_wr(`CSR_TLBEHI, 32'h1234_6000, val);
        csr_wr(`CSR_TLBELO0, 32'h0001_2301, val);
        csr_wr(`CSR_ASID, 32'h5, val);
        tlb_op(INST_TLBFILL, 32'h0, 32'h0);
        tlb_op(INST_TLBSRCH, 32'h0, 32'h0);
        csr_rd(`CSR_TLBIDX, val);
        if ({val[31], val[2:0]} !== 4'h0) mismatch("ne/index", 32'h0, {val[31], val[2:0]});
        finish_test();
    endtask

    task automatic tlb_write_read();
        logic [31:0] val;
        start_test("tlb_write_read");
        csr_wr(`CSR_TLBIDX, 32'h3, val);
        csr_wr(`CSR_TLBEHI, 32'h0abc_e000, val);
        csr_wr(`CSR_TLBELO0, 32'h0004_5601, val);
        csr_wr(`CSR_ASID, 32'h9, val);
        tlb_op(INST_TLBWR, 32'h0, 32'h0);
        // wipe the view so tlbrd has to bring it back
        csr_wr(`CSR_TLBEHI, 32'h0, val);
        csr_wr(`CSR_TLBELO0, 32'h0, val);
        csr_wr(`CSR_ASID, 32'h0, val);
        tlb_op(INST_TLBRD, 32'h0, 32'h0);
        csr_rd(`CSR_TLBEHI, val);
        if (val !== (32'h0abc_e000 & 32'hffff_e000)) mismatch("tlbehi", 32'h0abc_e000, val);
        csr_rd(`CSR_TLBELO0, val);
        if (val !== (32'h0004_5601 & 32'h0fff_ff01)) mismatch("tlbelo0", 32'h0004_5601, val);
        csr_rd(`CSR_ASID, val);
        if (val !== 32'h9) mismatch("asid", 32'h9, val);
        finish_test();
    endtask

    task automatic tlb_invalidate();
        logic [31:0] val;
        start_test("tlb_invalidate");
        csr_wr(`CSR_TLBEHI, 32'h1234_6000, val);
        csr_wr(`CSR_ASID, 32'h5, val);
        tlb_op(INST_TLBSRCH, 32'h0, 32'h0);
        csr_rd(`CSR_TLBIDX, val);
        if (val[31] !== 1'b0) mismatch("ne before invtlb", 32'h0, val[31]);
        tlb_op(INST_INVTLB | 32'd5, 32'h5, 32'h1234_6000); // asid and va match
        tlb_op(INST_TLBSRCH, 32'h0, 32'h0);
        csr_rd(`CSR_TLBIDX, val);
        if (val[31] !== 1'b1) mismatch("ne after invtlb", 32'h1, val[31]);
        // entry 3 has another asid and must survive
        csr_wr(`CSR_TLBEHI, 32'h0abc_e000, val);
        csr_wr(`CSR_ASID, 32'h9, val);
        tlb_op(INST_TLBSRCH, 32'h0, 32'h0);
        csr_rd(`CSR_TLBIDX, val);
        if ({val[31], val[2:0]} !== 4'h3) mismatch("ne/index kept", 32'h3, {val[31], val[2:0]});
        finish_test();
    endtask

    task automatic cache_maint();
        logic [31:0] val;
        start_test("cacop");
        cacop(2'd1, 2'd0, 32'h0000_2000, 12'h0);  // l1i index op
        cacop(2'd1, 2'd2, 32'h0000_2000, 12'h10); // l2 index op
        cacop(2'd2, 2'd1, 32'h0000_1001, 12'h2);  // l1d hit op, unaligned
        cacop(2'd2, 2'd1, 32'h0000_1000, 12'h4);
        csr_rd(`CSR_ERA, val);
        if (val !== 32'h8000_0040) mismatch("era after cacop", 32'h8000_0040, val);
        finish_test();
    endtask

    initial begin
        en_in = 1'b0;
        req   = '0;
        rstn  = 1'b0;
        pc    = 32'h1c00_0000;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        if (stall || en_out || flush) note_failure("outputs were not idle after reset");

        csr_rw_seq();
        ertn_return();
        tlb_fill_search();
        tlb_write_read();
        tlb_invalidate();
        cache_maint();

        $display("tests %0d, failing tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
